/* cv_pkg.sv */
/*
 * Console glue package: bus widths, memory and I/O maps,
 * wait-state and controller mode encodings
 */
`default_nettype none

package cv_pkg;

  // Bus widths
  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 8;
  // 1 KB RAM, mirrored over its 8 KB region
  localparam int RAM_AW     = 10;
  localparam int CART_BANKS = 4;

  // 10.7 MHz enables per 3.58 MHz enable
  localparam int CLK_DIV    = 3;
  localparam int DIV_W      = $clog2(CLK_DIV);
  // Reset stretch length in clocks
  localparam int POR_CYCLES = 4;
  localparam int POR_W      = $clog2(POR_CYCLES);

  // Undriven source reads as all ones
  localparam logic [DATA_W-1:0] BUS_IDLE = '1;

  // Memory map on A15..A13, 001 and 010 unused
  typedef enum logic [2:0] {
    BIOS    = 3'b000,
    RAM     = 3'b011,
    CART_80 = 3'b100,
    CART_A0 = 3'b101,
    CART_C0 = 3'b110,
    CART_E0 = 3'b111
  } mem_region_t;

  // I/O map on A7..A5
  typedef enum logic [2:0] {
    CTRL_KEY = 3'b100,
    VDP      = 3'b101,
    CTRL_JOY = 3'b110,
    PSG_CTRL = 3'b111
  } io_port_t;

  typedef enum logic [1:0] {WAIT_IDLE, WAIT_INSERT, WAIT_DONE} wait_state_t;

  typedef enum logic {CTRL_KEYPAD, CTRL_JOYSTICK} ctrl_mode_t;

endpackage

`default_nettype wire

/* cv_sel_if.sv */
/*
 * Decoded chip selects and controller strobes, all active low
 */
`timescale 1ns/1ps
`default_nettype none

interface cv_sel_if;

  logic                          bios_ce_n;
  logic                          ram_ce_n;
  // One enable per 8 KB cartridge window
  logic [cv_pkg::CART_BANKS-1:0] cart_en_n;
  logic                          vdp_r_n;
  // Controller read port
  logic                          ctrl_r_n;
  // Mode strobes for the controller latch
  logic                          ctrl_key_n;
  logic                          ctrl_joy_n;

  modport dec (output bios_ce_n, ram_ce_n, cart_en_n, vdp_r_n, ctrl_r_n,
               ctrl_key_n, ctrl_joy_n);
  modport mux (input bios_ce_n, ram_ce_n, cart_en_n, vdp_r_n, ctrl_r_n,
               ctrl_key_n, ctrl_joy_n);

endinterface

`default_nettype wire

/* cv_clk_reset.sv */
/*
 * Power-on reset stretcher and 3.58 MHz CPU clock-enable divider
 */
`timescale 1ns/1ps
`default_nettype none

module cv_clk_reset (
  input  logic clk_i,
  input  logic reset_n_i,
  input  logic clk_en_10m7_i,
  output logic reset_n_s,
  output logic clk_en_3m58_o
);

  import cv_pkg::*;

  logic [POR_W-1:0] por_cnt_q;
  logic             por_n_q;
  logic [DIV_W-1:0] div_cnt_q;

  // --------------------------------------------------
  // Reset stretcher
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge reset_n_i) begin
    if (!reset_n_i) begin
      por_cnt_q <= '0;
      por_n_q   <= 1'b0;
    end else if (!por_n_q) begin
      // Release on the last count
      if (por_cnt_q == POR_W'(POR_CYCLES - 1)) begin
        por_n_q <= 1'b1;
      end else begin
        por_cnt_q <= por_cnt_q + 1'b1;
      end
    end
  end

  assign reset_n_s = por_n_q;

  // --------------------------------------------------
  // Divide by three
  // --------------------------------------------------
  // Down counter stepping only on 10.7 MHz enables
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      div_cnt_q <= '0;
    end else if (clk_en_10m7_i) begin
      if (div_cnt_q == '0) begin
        div_cnt_q <= DIV_W'(CLK_DIV - 1);
      end else begin
        div_cnt_q <= div_cnt_q - 1'b1;
      end
    end
  end

  // Phase zero lets the 10.7 MHz enable through
  assign clk_en_3m58_o = clk_en_10m7_i && (div_cnt_q == '0);

  // Each CPU enable restarts the three-step phase
  a_en_reload: assert property (@(posedge clk_i) disable iff (!reset_n_s)
    clk_en_3m58_o |=> div_cnt_q == DIV_W'(CLK_DIV - 1));

endmodule

`default_nettype wire

/* cv_wait_ctrl.sv */
/*
 * M1 wait-state generator, one CPU period per opcode fetch,
 * merged with the sound chip ready line
 */
`timescale 1ns/1ps
`default_nettype none

module cv_wait_ctrl (
  input  logic clk_i,
  input  logic reset_n_s,
  input  logic clk_en_3m58_i,
  input  logic m1_n_i,
  input  logic psg_ready_i,
  output logic cpu_wait_n_o
);

  import cv_pkg::*;

  wait_state_t state_q;
  wait_state_t state_d;

  always_comb begin
    state_d = state_q;
    // End of fetch clears the machine
    if (m1_n_i) begin
      state_d = WAIT_IDLE;
    end else begin
      case (state_q)
        WAIT_IDLE:   if (clk_en_3m58_i) state_d = WAIT_INSERT;
        WAIT_INSERT: if (clk_en_3m58_i) state_d = WAIT_DONE;
        // Hold until M1 goes away
        default:     state_d = state_q;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      state_q <= WAIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Either source can stall the CPU
  assign cpu_wait_n_o = (state_q != WAIT_INSERT) && psg_ready_i;

  // Insert state only follows a fetch seen on a CPU enable
  a_insert_m1: assert property (@(posedge clk_i) disable iff (!reset_n_s)
    (state_q == WAIT_INSERT && $past(state_q) != WAIT_INSERT) |->
      $past(!m1_n_i && clk_en_3m58_i));

endmodule

`default_nettype wire

/* cv_addr_dec.sv */
/*
 * Memory and I/O address decoder with active-low chip selects
 */
`timescale 1ns/1ps
`default_nettype none

module cv_addr_dec (
  input  logic [cv_pkg::ADDR_W-1:0] a_i,
  input  logic                      mreq_n_i,
  input  logic                      iorq_n_i,
  input  logic                      rd_n_i,
  input  logic                      wr_n_i,
  input  logic                      rfsh_n_i,
  input  logic                      m1_n_i,
  cv_sel_if.dec                     sel,
  output logic                      vdp_w_n_o,
  output logic                      psg_we_n_o
);

  import cv_pkg::*;

  mem_region_t           region_s;
  io_port_t              port_s;
  logic                  mem_acc_s;
  logic                  io_cyc_s;
  logic                  bios_ce_n_s;
  logic                  ram_ce_n_s;
  logic [CART_BANKS-1:0] cart_en_n_s;
  logic                  vdp_r_n_s;
  logic                  ctrl_r_n_s;
  logic                  ctrl_key_n_s;
  logic                  ctrl_joy_n_s;

  // Top three address bits pick the 8 KB region
  assign region_s = mem_region_t'(a_i[ADDR_W-1 -: 3]);
  assign port_s   = io_port_t'(a_i[7:5]);

  // Refresh cycles carry MREQ too
  assign mem_acc_s = !mreq_n_i && rfsh_n_i && (!rd_n_i || !wr_n_i);
  // Interrupt acknowledge has IORQ with M1
  assign io_cyc_s  = !iorq_n_i && m1_n_i;

  // --------------------------------------------------
  // Memory map
  // --------------------------------------------------
  always_comb begin
    bios_ce_n_s = 1'b1;
    ram_ce_n_s  = 1'b1;
    cart_en_n_s = '1;
    if (mem_acc_s) begin
      case (region_s)
        BIOS:    bios_ce_n_s    = 1'b0;
        // RAM ignores A12..A10, hence the mirror
        RAM:     ram_ce_n_s     = 1'b0;
        CART_80: cart_en_n_s[0] = 1'b0;
        CART_A0: cart_en_n_s[1] = 1'b0;
        CART_C0: cart_en_n_s[2] = 1'b0;
        CART_E0: cart_en_n_s[3] = 1'b0;
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // I/O map
  // --------------------------------------------------
  always_comb begin
    vdp_r_n_s    = 1'b1;
    vdp_w_n_o    = 1'b1;
    ctrl_r_n_s   = 1'b1;
    ctrl_key_n_s = 1'b1;
    ctrl_joy_n_s = 1'b1;
    psg_we_n_o   = 1'b1;
    if (io_cyc_s) begin
      case (port_s)
        CTRL_KEY: ctrl_key_n_s = wr_n_i;
        VDP: begin
          vdp_r_n_s = rd_n_i;
          vdp_w_n_o = wr_n_i;
        end
        CTRL_JOY: ctrl_joy_n_s = wr_n_i;
        // Same port: write goes to the PSG, read to controllers
        PSG_CTRL: begin
          psg_we_n_o = wr_n_i;
          ctrl_r_n_s = rd_n_i;
        end
        default: ;
      endcase
    end
  end

  assign sel.bios_ce_n  = bios_ce_n_s;
  assign sel.ram_ce_n   = ram_ce_n_s;
  assign sel.cart_en_n  = cart_en_n_s;
  assign sel.vdp_r_n    = vdp_r_n_s;
  assign sel.ctrl_r_n   = ctrl_r_n_s;
  assign sel.ctrl_key_n = ctrl_key_n_s;
  assign sel.ctrl_joy_n = ctrl_joy_n_s;

  // Memory and I/O selects never overlap
  always_comb begin
    a_one_sel: assert ($onehot0({~bios_ce_n_s, ~ram_ce_n_s, ~cart_en_n_s, ~vdp_r_n_s,
                                 ~vdp_w_n_o, ~ctrl_r_n_s, ~ctrl_key_n_s,
                                 ~ctrl_joy_n_s, ~psg_we_n_o}));
  end

endmodule

`default_nettype wire

/* cv_bus_mux.sv */
/*
 * Controller mode latch and AND-combined read-data multiplexer
 */
`timescale 1ns/1ps
`default_nettype none

module cv_bus_mux (
  input  logic                      clk_i,
  input  logic                      reset_n_s,
  input  logic                      a1_i,
  cv_sel_if.mux                     sel,
  input  logic [cv_pkg::DATA_W-1:0] bios_d_i,
  input  logic [cv_pkg::DATA_W-1:0] ram_d_i,
  input  logic [cv_pkg::DATA_W-1:0] cart_d_i,
  input  logic [cv_pkg::DATA_W-1:0] vdp_d_i,
  input  logic [cv_pkg::DATA_W-1:0] key_p1_i,
  input  logic [cv_pkg::DATA_W-1:0] key_p2_i,
  input  logic [cv_pkg::DATA_W-1:0] joy_p1_i,
  input  logic [cv_pkg::DATA_W-1:0] joy_p2_i,
  output logic [cv_pkg::DATA_W-1:0] d_to_cpu_o
);

  import cv_pkg::*;

  ctrl_mode_t        mode_q;
  logic [DATA_W-1:0] ctrl_d_s;

  // Scan mode follows the last strobe written
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      mode_q <= CTRL_KEYPAD;
    end else if (!sel.ctrl_key_n) begin
      mode_q <= CTRL_KEYPAD;
    end else if (!sel.ctrl_joy_n) begin
      mode_q <= CTRL_JOYSTICK;
    end
  end

  // A1 low reads player 1
  always_comb begin
    if (mode_q == CTRL_KEYPAD) begin
      ctrl_d_s = a1_i ? key_p2_i : key_p1_i;
    end else begin
      ctrl_d_s = a1_i ? joy_p2_i : joy_p1_i;
    end
  end

  // --------------------------------------------------
  // Masked sources ANDed onto the CPU bus
  // --------------------------------------------------
  always_comb begin
    logic [DATA_W-1:0] bios_v;
    logic [DATA_W-1:0] ram_v;
    logic [DATA_W-1:0] cart_v;
    logic [DATA_W-1:0] vdp_v;
    logic [DATA_W-1:0] ctrl_v;
    bios_v = sel.bios_ce_n ? BUS_IDLE : bios_d_i;
    ram_v  = sel.ram_ce_n ? BUS_IDLE : ram_d_i;
    // All windows share one cartridge bus
    cart_v = (&sel.cart_en_n) ? BUS_IDLE : cart_d_i;
    vdp_v  = sel.vdp_r_n ? BUS_IDLE : vdp_d_i;
    ctrl_v = sel.ctrl_r_n ? BUS_IDLE : ctrl_d_s;
    d_to_cpu_o = bios_v & ram_v & cart_v & vdp_v & ctrl_v;
  end

endmodule

`default_nettype wire

/* cv_glue_top.sv */
/*
 * Console glue chip: reset, CPU clock enable, wait states,
 * address decode and read-data multiplexer on a Z80 bus
 */
`timescale 1ns/1ps
`default_nettype none

module cv_glue_top (
  input  logic                          clk_i,
  input  logic                          reset_n_i,
  input  logic                          clk_en_10m7_i,
  // Z80 bus
  input  logic [cv_pkg::ADDR_W-1:0]     a_i,
  input  logic                          mreq_n_i,
  input  logic                          iorq_n_i,
  input  logic                          rd_n_i,
  input  logic                          wr_n_i,
  input  logic                          rfsh_n_i,
  input  logic                          m1_n_i,
  input  logic                          psg_ready_i,
  // Read data sources
  input  logic [cv_pkg::DATA_W-1:0]     bios_d_i,
  input  logic [cv_pkg::DATA_W-1:0]     ram_d_i,
  input  logic [cv_pkg::DATA_W-1:0]     cart_d_i,
  input  logic [cv_pkg::DATA_W-1:0]     vdp_d_i,
  input  logic [cv_pkg::DATA_W-1:0]     key_p1_i,
  input  logic [cv_pkg::DATA_W-1:0]     key_p2_i,
  input  logic [cv_pkg::DATA_W-1:0]     joy_p1_i,
  input  logic [cv_pkg::DATA_W-1:0]     joy_p2_i,
  output logic                          por_n_o,
  output logic                          clk_en_3m58_o,
  output logic                          cpu_wait_n_o,
  // Chip selects
  output logic                          bios_ce_n_o,
  output logic                          ram_ce_n_o,
  output logic [cv_pkg::CART_BANKS-1:0] cart_en_n_o,
  output logic                          vdp_r_n_o,
  output logic                          vdp_w_n_o,
  output logic                          psg_we_n_o,
  output logic [cv_pkg::DATA_W-1:0]     d_to_cpu_o
);

  import cv_pkg::*;

  logic reset_n_s;
  logic clk_en_3m58_s;

  cv_sel_if sel_if ();

  cv_clk_reset clk_reset_inst (
    .clk_i         (clk_i),
    .reset_n_i     (reset_n_i),
    .clk_en_10m7_i (clk_en_10m7_i),
    .reset_n_s     (reset_n_s),
    .clk_en_3m58_o (clk_en_3m58_s)
  );

  cv_wait_ctrl wait_ctrl_inst (
    .clk_i         (clk_i),
    .reset_n_s     (reset_n_s),
    .clk_en_3m58_i (clk_en_3m58_s),
    .m1_n_i        (m1_n_i),
    .psg_ready_i   (psg_ready_i),
    .cpu_wait_n_o  (cpu_wait_n_o)
  );

  cv_addr_dec addr_dec_inst (
    .a_i        (a_i),
    .mreq_n_i   (mreq_n_i),
    .iorq_n_i   (iorq_n_i),
    .rd_n_i     (rd_n_i),
    .wr_n_i     (wr_n_i),
    .rfsh_n_i   (rfsh_n_i),
    .m1_n_i     (m1_n_i),
    .sel        (sel_if.dec),
    .vdp_w_n_o  (vdp_w_n_o),
    .psg_we_n_o (psg_we_n_o)
  );

  // Player select comes straight off A1
  cv_bus_mux bus_mux_inst (
    .clk_i      (clk_i),
    .reset_n_s  (reset_n_s),
    .a1_i       (a_i[1]),
    .sel        (sel_if.mux),
    .bios_d_i   (bios_d_i),
    .ram_d_i    (ram_d_i),
    .cart_d_i   (cart_d_i),
    .vdp_d_i    (vdp_d_i),
    .key_p1_i   (key_p1_i),
    .key_p2_i   (key_p2_i),
    .joy_p1_i   (joy_p1_i),
    .joy_p2_i   (joy_p2_i),
    .d_to_cpu_o (d_to_cpu_o)
  );

  // Stretched reset doubles as the board reset
  assign por_n_o       = reset_n_s;
  assign clk_en_3m58_o = clk_en_3m58_s;

  assign bios_ce_n_o = sel_if.bios_ce_n;
  assign ram_ce_n_o  = sel_if.ram_ce_n;
  assign cart_en_n_o = sel_if.cart_en_n;
  assign vdp_r_n_o   = sel_if.vdp_r_n;

endmodule

`default_nettype wire

/* tb_cv_glue.sv */
/*
 * Testbench for the console glue chip: LCG bus stimulus,
 * cycle-based reference model and per-cycle output checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cv_glue;

  import cv_pkg::*;

  localparam int CLK_HALF      = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int N_TRANS       = 400;
  localparam int BUS_HOLD      = 8;
  // Reset, POR stretch, all bus cycles, then some margin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + POR_CYCLES + N_TRANS * BUS_HOLD + 200;

  logic                  clk_i = 1'b0;
  logic                  reset_n_i;
  logic                  clk_en_10m7_i;
  logic [ADDR_W-1:0]     a_i;
  logic                  mreq_n_i;
  logic                  iorq_n_i;
  logic                  rd_n_i;
  logic                  wr_n_i;
  logic                  rfsh_n_i;
  logic                  m1_n_i;
  logic                  psg_ready_i;
  logic [DATA_W-1:0]     bios_d_i;
  logic [DATA_W-1:0]     ram_d_i;
  logic [DATA_W-1:0]     cart_d_i;
  logic [DATA_W-1:0]     vdp_d_i;
  logic [DATA_W-1:0]     key_p1_i;
  logic [DATA_W-1:0]     key_p2_i;
  logic [DATA_W-1:0]     joy_p1_i;
  logic [DATA_W-1:0]     joy_p2_i;
  logic                  por_n_o;
  logic                  clk_en_3m58_o;
  logic                  cpu_wait_n_o;
  logic                  bios_ce_n_o;
  logic                  ram_ce_n_o;
  logic [CART_BANKS-1:0] cart_en_n_o;
  logic                  vdp_r_n_o;
  logic                  vdp_w_n_o;
  logic                  psg_we_n_o;
  logic [DATA_W-1:0]     d_to_cpu_o;

  logic [31:0] rng_state;
  int          error_count = 0;
  int          check_count = 0;
  int          key_reads = 0;
  int          joy_reads = 0;

  // Model state
  logic        m_por = 1'b0;
  int          m_por_cnt = 0;
  int          m_div = 0;
  wait_state_t m_wait = WAIT_IDLE;
  ctrl_mode_t  m_mode = CTRL_KEYPAD;
  int          por_wait = 0;
  logic        por_seen = 1'b0;

  cv_glue_top cv_glue_top_inst (.*);

  always #CLK_HALF clk_i = ~clk_i;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // LCG step, upper half has the better bits
  function automatic logic [15:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] t=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
    end
  endtask

  // Memory, I/O or idle cycle with fresh source data
  task automatic start_bus_cycle();
    logic [15:0] r;
    logic [15:0] addr;
    logic        is_rd;
    r     = next_rand();
    addr  = next_rand();
    is_rd = r[0];
    case (r[2:1])
      2'd0, 2'd1: begin
        mreq_n_i <= 1'b0;
        iorq_n_i <= 1'b1;
        rfsh_n_i <= (r[5:3] != 3'd0);
        m1_n_i   <= r[6];
        a_i      <= addr;
        rd_n_i   <= !is_rd;
        wr_n_i   <= is_rd;
      end
      2'd2: begin
        mreq_n_i <= 1'b1;
        iorq_n_i <= 1'b0;
        rfsh_n_i <= 1'b1;
        // M1 with IORQ is an interrupt acknowledge, keep it rare
        m1_n_i   <= (r[5:3] != 3'd0);
        a_i      <= {addr[15:8], (r[9:7] != 3'd0), r[11:10], addr[4:0]};
        rd_n_i   <= !is_rd;
        wr_n_i   <= is_rd;
      end
      default: begin
        mreq_n_i <= 1'b1;
        iorq_n_i <= 1'b1;
        rfsh_n_i <= 1'b1;
        m1_n_i   <= r[6];
        a_i      <= addr;
        rd_n_i   <= 1'b1;
        wr_n_i   <= 1'b1;
      end
    endcase
    r = next_rand();
    bios_d_i <= r[7:0];
    ram_d_i  <= r[15:8];
    r = next_rand();
    cart_d_i <= r[7:0];
    vdp_d_i  <= r[15:8];
    r = next_rand();
    key_p1_i <= r[7:0];
    key_p2_i <= r[15:8];
    r = next_rand();
    joy_p1_i <= r[7:0];
    joy_p2_i <= r[15:8];
  endtask

  // One clock: fast enable one in three, PSG mostly ready
  task automatic step_clock(input logic new_bus);
    @(posedge clk_i);
    clk_en_10m7_i <= ((next_rand() % 16'd3) == 16'd0);
    psg_ready_i   <= ((next_rand() % 16'd8) != 16'd0);
    if (new_bus) begin
      start_bus_cycle();
    end
  endtask

  // --------------------------------------------------
  // Reference model and checks, on the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin : model_check
    logic                  mem_s;
    logic                  io_s;
    logic                  e_bios;
    logic                  e_ram;
    logic [CART_BANKS-1:0] e_cart;
    logic                  e_vdp_r;
    logic                  e_vdp_w;
    logic                  e_ctrl_r;
    logic                  e_key;
    logic                  e_joy;
    logic                  e_psg;
    logic                  e_en3;
    logic [DATA_W-1:0]     e_ctrl_d;
    logic [DATA_W-1:0]     e_data;
    logic                  por_now;
    int                    low_cnt;
    mem_s    = !mreq_n_i && rfsh_n_i && (!rd_n_i || !wr_n_i);
    io_s     = !iorq_n_i && m1_n_i;
    e_bios   = !(mem_s && a_i[15:13] == 3'b000);
    e_ram    = !(mem_s && a_i[15:13] == 3'b011);
    e_cart   = '1;
    if (mem_s && a_i[15]) begin
      e_cart[a_i[14:13]] = 1'b0;
    end
    // I/O ports on A7..A5
    e_key    = !(io_s && a_i[7:5] == 3'b100 && !wr_n_i);
    e_vdp_r  = !(io_s && a_i[7:5] == 3'b101 && !rd_n_i);
    e_vdp_w  = !(io_s && a_i[7:5] == 3'b101 && !wr_n_i);
    e_joy    = !(io_s && a_i[7:5] == 3'b110 && !wr_n_i);
    e_psg    = !(io_s && a_i[7:5] == 3'b111 && !wr_n_i);
    e_ctrl_r = !(io_s && a_i[7:5] == 3'b111 && !rd_n_i);
    e_en3    = clk_en_10m7_i && (m_div == 0);
    if (m_mode == CTRL_KEYPAD) begin
      e_ctrl_d = a_i[1] ? key_p2_i : key_p1_i;
    end else begin
      e_ctrl_d = a_i[1] ? joy_p2_i : joy_p1_i;
    end
    // Wired-AND read bus
    e_data = BUS_IDLE;
    if (!e_bios)   e_data = e_data & bios_d_i;
    if (!e_ram)    e_data = e_data & ram_d_i;
    if (!(&e_cart)) e_data = e_data & cart_d_i;
    if (!e_vdp_r)  e_data = e_data & vdp_d_i;
    if (!e_ctrl_r) e_data = e_data & e_ctrl_d;

    check_value("por_n_o", 32'(por_n_o), 32'(m_por));
    check_value("clk_en_3m58_o", 32'(clk_en_3m58_o), 32'(e_en3));
    check_value("cpu_wait_n_o", 32'(cpu_wait_n_o),
                32'((m_wait != WAIT_INSERT) && psg_ready_i));
    check_value("bios_ce_n_o", 32'(bios_ce_n_o), 32'(e_bios));
    check_value("ram_ce_n_o", 32'(ram_ce_n_o), 32'(e_ram));
    check_value("cart_en_n_o", 32'(cart_en_n_o), 32'(e_cart));
    check_value("vdp_r_n_o", 32'(vdp_r_n_o), 32'(e_vdp_r));
    check_value("vdp_w_n_o", 32'(vdp_w_n_o), 32'(e_vdp_w));
    check_value("psg_we_n_o", 32'(psg_we_n_o), 32'(e_psg));
    if (!rd_n_i) begin
      check_value("d_to_cpu_o", 32'(d_to_cpu_o), 32'(e_data));
      if (!e_ctrl_r && m_mode == CTRL_KEYPAD) key_reads++;
      if (!e_ctrl_r && m_mode == CTRL_JOYSTICK) joy_reads++;
    end

    low_cnt = 0;
    if (!bios_ce_n_o) low_cnt++;
    if (!ram_ce_n_o) low_cnt++;
    for (int i = 0; i < CART_BANKS; i++) begin
      if (!cart_en_n_o[i]) low_cnt++;
    end
    if (!vdp_r_n_o) low_cnt++;
    if (!vdp_w_n_o) low_cnt++;
    if (!psg_we_n_o) low_cnt++;
    if (low_cnt > 1) begin
      error_count++;
      $display("[ERROR] t=%0t more than one chip select is active at once", $time);
    end

    // Stretch length, counted from the release edge
    if (reset_n_i && !por_seen) begin
      if (por_n_o) begin
        por_seen = 1'b1;
        check_value("por_delay", 32'(por_wait), 32'(POR_CYCLES));
      end else begin
        por_wait++;
      end
    end

    // Advance the model to the next rising edge
    por_now = m_por;
    if (!por_now) begin
      m_div  = 0;
      m_wait = WAIT_IDLE;
      m_mode = CTRL_KEYPAD;
    end else begin
      if (clk_en_10m7_i) m_div = (m_div == 0) ? CLK_DIV - 1 : m_div - 1;
      if (m1_n_i) begin
        m_wait = WAIT_IDLE;
      end else if (m_wait == WAIT_IDLE && e_en3) begin
        m_wait = WAIT_INSERT;
      end else if (m_wait == WAIT_INSERT && e_en3) begin
        m_wait = WAIT_DONE;
      end
      if (!e_key) begin
        m_mode = CTRL_KEYPAD;
      end else if (!e_joy) begin
        m_mode = CTRL_JOYSTICK;
      end
    end
    if (!reset_n_i) begin
      m_por     = 1'b0;
      m_por_cnt = 0;
    end else if (!m_por) begin
      if (m_por_cnt == POR_CYCLES - 1) m_por = 1'b1;
      else m_por_cnt++;
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : stimulus
    rng_state     = 32'h7eb;
    reset_n_i     = 1'b0;
    clk_en_10m7_i = 1'b0;
    a_i           = '0;
    mreq_n_i      = 1'b1;
    iorq_n_i      = 1'b1;
    rd_n_i        = 1'b1;
    wr_n_i        = 1'b1;
    rfsh_n_i      = 1'b1;
    m1_n_i        = 1'b1;
    psg_ready_i   = 1'b1;
    bios_d_i      = '0;
    ram_d_i       = '0;
    cart_d_i      = '0;
    vdp_d_i       = '0;
    key_p1_i      = '0;
    key_p2_i      = '0;
    joy_p1_i      = '0;
    joy_p2_i      = '0;
    repeat (RESET_CYCLES) step_clock(1'b0);
    step_clock(1'b0);
    reset_n_i <= 1'b1;
    // Let the reset stretch run out
    repeat (POR_CYCLES + 2) step_clock(1'b0);
    for (int n = 0; n < N_TRANS; n++) begin
      step_clock(1'b1);
      repeat (BUS_HOLD - 1) step_clock(1'b0);
    end
    repeat (2) step_clock(1'b0);
    if (!por_seen) begin
      error_count++;
      $display("[ERROR] stretched reset never released");
    end
    if (key_reads == 0 || joy_reads == 0) begin
      error_count++;
      $display("[ERROR] controller reads not seen in both scan modes");
    end
    $display("Checks: %0d, errors: %0d, keypad reads: %0d, joystick reads: %0d",
             check_count, error_count, key_reads, joy_reads);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("simulation timed out after %0d clocks", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
cv_pkg.sv
cv_sel_if.sv
cv_clk_reset.sv
cv_wait_ctrl.sv
cv_addr_dec.sv
cv_bus_mux.sv
cv_glue_top.sv
tb_cv_glue.sv

/* run.sh */
#!/bin/sh
# Compile and run the console glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cv_glue -f files.f -o tb_cv_glue_sim

./obj_dir/tb_cv_glue_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi
